//--- all.f
+incdir+include
design/gb_exec_pkg.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_queue.sv
design/gb_exec_core.sv
verification/tb_gb_exec.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the gb_exec_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f all.f \
   --top-module tb_gb_exec \
   -Mdir obj_dir

sim_output=$(./obj_dir/Vtb_gb_exec)
echo "$sim_output"

if grep -qx "Finished with no errors" <<< "$sim_output"; then
   exit 0
else
   exit 1
fi

//--- include/tb_cases.svh
`ifndef TB_CASES_SVH
`define TB_CASES_SVH
`default_nettype none

// Columns are name, opcode, immediate, value, flags ZNHC, taken and illegal
// Cases chain from the all-zero reset state
task automatic load_directed_cases();
   // Immediate loads followed by register moves
   add_case("ld_b_n",          8'h06, 8'h12, 8'h12, 4'h0, 1'b0, 1'b0);
   add_case("ld_c_n",          8'h0e, 8'h34, 8'h34, 4'h0, 1'b0, 1'b0);
   add_case("ld_d_n",          8'h16, 8'h56, 8'h56, 4'h0, 1'b0, 1'b0);
   add_case("ld_e_n",          8'h1e, 8'h78, 8'h78, 4'h0, 1'b0, 1'b0);
   add_case("ld_h_n",          8'h26, 8'h9a, 8'h9a, 4'h0, 1'b0, 1'b0);
   add_case("ld_l_n",          8'h2e, 8'hbc, 8'hbc, 4'h0, 1'b0, 1'b0);
   add_case("ld_a_n",          8'h3e, 8'h0f, 8'h0f, 4'h0, 1'b0, 1'b0);
   add_case("ld_a_b",          8'h78, 8'h00, 8'h12, 4'h0, 1'b0, 1'b0);
   add_case("ld_d_l",          8'h55, 8'h00, 8'hbc, 4'h0, 1'b0, 1'b0);
   add_case("ld_h_a",          8'h67, 8'h00, 8'h12, 4'h0, 1'b0, 1'b0);
   add_case("ld_b_c",          8'h41, 8'h00, 8'h34, 4'h0, 1'b0, 1'b0);
   // ALU cases from A=12 B=34 C=34 D=bc E=78 H=12 L=bc
   add_case("add_a_b",         8'h80, 8'h00, 8'h46, 4'h0, 1'b0, 1'b0);
   add_case("add_n_half",      8'hc6, 8'h3a, 8'h80, 4'h2, 1'b0, 1'b0);
   add_case("add_n_carry",     8'hc6, 8'h90, 8'h10, 4'h1, 1'b0, 1'b0);
   add_case("adc_n_carry_in",  8'hce, 8'h0f, 8'h20, 4'h2, 1'b0, 1'b0);
   add_case("add_n_zero",      8'hc6, 8'he0, 8'h00, 4'h9, 1'b0, 1'b0);
   add_case("adc_a_c",         8'h89, 8'h00, 8'h35, 4'h0, 1'b0, 1'b0);
   add_case("sub_a_d",         8'h92, 8'h00, 8'h79, 4'h7, 1'b0, 1'b0);
   add_case("sbc_n_borrow_in", 8'hde, 8'h08, 8'h70, 4'h4, 1'b0, 1'b0);
   add_case("sub_n_zero",      8'hd6, 8'h70, 8'h00, 4'hc, 1'b0, 1'b0);
   add_case("sbc_n_borrow",    8'hde, 8'h01, 8'hff, 4'h7, 1'b0, 1'b0);
   add_case("sbc_a_a",         8'h9f, 8'h00, 8'hff, 4'h7, 1'b0, 1'b0);
   add_case("and_a_e",         8'ha3, 8'h00, 8'h78, 4'h2, 1'b0, 1'b0);
   add_case("and_n_zero",      8'he6, 8'h87, 8'h00, 4'ha, 1'b0, 1'b0);
   add_case("or_n",            8'hf6, 8'h5a, 8'h5a, 4'h0, 1'b0, 1'b0);
   add_case("xor_n",           8'hee, 8'hff, 8'ha5, 4'h0, 1'b0, 1'b0);
   add_case("xor_n_restore",   8'hee, 8'hff, 8'h5a, 4'h0, 1'b0, 1'b0);
   add_case("xor_a_h",         8'hac, 8'h00, 8'h48, 4'h0, 1'b0, 1'b0);
   add_case("xor_a_a",         8'haf, 8'h00, 8'h00, 4'h8, 1'b0, 1'b0);
   add_case("or_a_l",          8'hb5, 8'h00, 8'hbc, 4'h0, 1'b0, 1'b0);
   add_case("cp_a_d_equal",    8'hba, 8'h00, 8'hbc, 4'hc, 1'b0, 1'b0);
   add_case("cp_n_borrow",     8'hfe, 8'hc0, 8'hbc, 4'h5, 1'b0, 1'b0);
   // Jumps with N and C set and Z clear
   add_case("jr_nz_taken",     8'h20, 8'h05, 8'h00, 4'h5, 1'b1, 1'b0);
   add_case("jr_z_not",        8'h28, 8'h05, 8'h00, 4'h5, 1'b0, 1'b0);
   add_case("jr_nc_not",       8'h30, 8'h05, 8'h00, 4'h5, 1'b0, 1'b0);
   add_case("jr_c_taken",      8'h38, 8'h05, 8'h00, 4'h5, 1'b1, 1'b0);
   // INC and DEC wrap and keep the carry
   add_case("ld_e_ff",         8'h1e, 8'hff, 8'hff, 4'h5, 1'b0, 1'b0);
   add_case("inc_e_wrap",      8'h1c, 8'h00, 8'h00, 4'hb, 1'b0, 1'b0);
   add_case("jr_z_taken",      8'h28, 8'h00, 8'h00, 4'hb, 1'b1, 1'b0);
   add_case("jr_nz_not",       8'h20, 8'h00, 8'h00, 4'hb, 1'b0, 1'b0);
   add_case("dec_e_wrap",      8'h1d, 8'h00, 8'hff, 4'h7, 1'b0, 1'b0);
   add_case("add_n_clear",     8'hc6, 8'h01, 8'hbd, 4'h0, 1'b0, 1'b0);
   add_case("inc_b",           8'h04, 8'h00, 8'h35, 4'h0, 1'b0, 1'b0);
   add_case("dec_c",           8'h0d, 8'h00, 8'h33, 4'h4, 1'b0, 1'b0);
   add_case("jr_nc_taken",     8'h30, 8'h00, 8'h00, 4'h4, 1'b1, 1'b0);
   add_case("jr_c_not",        8'h38, 8'h00, 8'h00, 4'h4, 1'b0, 1'b0);
   add_case("ld_a_zero",       8'h3e, 8'h00, 8'h00, 4'h4, 1'b0, 1'b0);
   add_case("dec_a_wrap",      8'h3d, 8'h00, 8'hff, 4'h6, 1'b0, 1'b0);
   add_case("inc_a_wrap",      8'h3c, 8'h00, 8'h00, 4'ha, 1'b0, 1'b0);
   // Illegal forms report current flags and touch nothing
   add_case("ld_b_mem",        8'h46, 8'h00, 8'h00, 4'ha, 1'b0, 1'b1);
   add_case("ld_mem_c",        8'h71, 8'h00, 8'h00, 4'ha, 1'b0, 1'b1);
   add_case("halt",            8'h76, 8'h00, 8'h00, 4'ha, 1'b0, 1'b1);
   add_case("add_mem",         8'h86, 8'h00, 8'h00, 4'ha, 1'b0, 1'b1);
   add_case("inc_mem",         8'h34, 8'h00, 8'h00, 4'ha, 1'b0, 1'b1);
   add_case("ld_mem_n",        8'h36, 8'h55, 8'h00, 4'ha, 1'b0, 1'b1);
   add_case("nop",             8'h00, 8'h00, 8'h00, 4'ha, 1'b0, 1'b1);
   add_case("cb_prefix",       8'hcb, 8'h00, 8'h00, 4'ha, 1'b0, 1'b1);
   // Read back through LD r,r
   add_case("read_b",          8'h40, 8'h00, 8'h35, 4'ha, 1'b0, 1'b0);
   add_case("read_c",          8'h49, 8'h00, 8'h33, 4'ha, 1'b0, 1'b0);
   add_case("read_a",          8'h7f, 8'h00, 8'h00, 4'ha, 1'b0, 1'b0);
endtask

`default_nettype wire
`endif

//--- verification/tb_gb_exec.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gb_exec;
   import gb_exec_pkg::*;

   localparam int IN_DEPTH    = 4;
   localparam int OUT_CREDITS = 2;
   localparam int CLK_PERIOD  = 40;
   localparam int DRIVE_DELAY = 2;
   localparam int WAIT_LIMIT  = 2000;
   localparam int NUM_RANDOM  = 64;

   logic    clock;
   logic    reset;
   logic    instr_valid;
   instr_t  instr;
   logic    out_credit;
   logic    in_credit;
   logic    result_valid;
   result_t result;

   // Expected stream in send order
   string   exp_name [$];
   instr_t  exp_instr [$];
   result_t exp_result [$];

   int error_count;
   int pass_count;
   int sent_count;
   int in_credit_count;
   int recv_count;
   int returned_count;

   logic [31:0] lcg_state = 32'h04e2_2bb0;

   // Reference state for the random run
   logic [7:0] model_regs [8];
   logic [3:0] model_flags;

   gb_exec_core #(
      .IN_DEPTH    (IN_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) u_dut (
      .clock        (clock),
      .reset        (reset),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .out_credit   (out_credit),
      .in_credit    (in_credit),
      .result_valid (result_valid),
      .result       (result)
   );

   initial begin
      clock = 1'b0;
      forever #(CLK_PERIOD / 2) clock = ~clock;
   end

   // Returned input credits counted mid-cycle
   always @(negedge clock) begin
      if (in_credit === 1'b1) begin
         in_credit_count++;
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic add_case(string name, logic [7:0] opcode, logic [7:0] imm,
                           logic [7:0] value, logic [3:0] flags, logic taken,
                           logic illegal);
      instr_t  item;
      result_t rec;
      item.opcode = opcode;
      item.imm    = imm;
      rec.opcode  = opcode;
      rec.value   = value;
      rec.flags   = flags;
      rec.taken   = taken;
      rec.illegal = illegal;
      exp_name.push_back(name);
      exp_instr.push_back(item);
      exp_result.push_back(rec);
   endtask

   // Value and flags of an ALU operation on A from the flag rules
   function automatic logic [11:0] model_alu(alu_op_t op, logic [7:0] a, logic [7:0] b,
                                             logic carry);
      int         cin;
      int         full;
      int         half;
      logic [7:0] val;
      logic [3:0] f;
      cin = (op == ALU_ADC || op == ALU_SBC) ? int'(carry) : 0;
      f   = 4'b0000;
      val = 8'h00;
      case (op)
         ALU_ADD, ALU_ADC: begin
            full      = int'(a) + int'(b) + cin;
            half      = int'(a[3:0]) + int'(b[3:0]) + cin;
            val       = 8'(full);
            f[FLAG_H] = (half > 15);
            f[FLAG_C] = (full > 255);
         end
         ALU_SUB, ALU_SBC, ALU_CP: begin
            full      = int'(a) - int'(b) - cin;
            half      = int'(a[3:0]) - int'(b[3:0]) - cin;
            val       = 8'(full);
            f[FLAG_N] = 1'b1;
            f[FLAG_H] = (half < 0);
            f[FLAG_C] = (full < 0);
         end
         ALU_AND: begin
            val       = a & b;
            f[FLAG_H] = 1'b1;
         end
         ALU_XOR: val = a ^ b;
         ALU_OR:  val = a | b;
      endcase
      f[FLAG_Z] = (val == 8'h00);
      // Compare reports A itself
      if (op == ALU_CP) begin
         val = a;
      end
      return {val, f};
   endfunction

   // Random LD r,n and ALU immediate cases that start where the table ends
   task automatic build_random_cases();
      result_t     last;
      logic [31:0] pick;
      logic [2:0]  r;
      logic [7:0]  imm;
      alu_op_t     op;
      logic [11:0] alu_out;
      last        = exp_result[exp_result.size() - 1];
      model_flags = last.flags;
      // Load every register first so the model knows A
      for (int i = 0; i < 8; i++) begin
         if (i != 6) begin
            pick          = lcg_next();
            r             = 3'(i);
            model_regs[i] = pick[23:16];
            add_case($sformatf("rand_ld_%0d", i), {2'b00, r, 3'b110}, pick[23:16],
                     pick[23:16], model_flags, 1'b0, 1'b0);
         end
      end
      for (int i = 0; i < NUM_RANDOM; i++) begin
         pick = lcg_next();
         imm  = pick[15:8];
         if (pick[31:30] == 2'b00) begin
            r = (pick[26:24] == 3'd6) ? 3'd7 : pick[26:24];
            model_regs[r] = imm;
            add_case($sformatf("rand_%0d_ld", i), {2'b00, r, 3'b110}, imm, imm,
                     model_flags, 1'b0, 1'b0);
         end else begin
            op      = alu_op_t'(pick[18:16]);
            alu_out = model_alu(op, model_regs[7], imm, model_flags[FLAG_C]);
            if (op != ALU_CP) begin
               model_regs[7] = alu_out[11:4];
            end
            model_flags = alu_out[3:0];
            add_case($sformatf("rand_%0d_alu", i), {2'b11, pick[18:16], 3'b110}, imm,
                     alu_out[11:4], alu_out[3:0], 1'b0, 1'b0);
         end
      end
   endtask

   task automatic finish_run();
      $display("Tests: %0d, passed: %0d, errors: %0d", exp_result.size(), pass_count,
               error_count);
      if (error_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   task automatic fail_timeout(string what);
      $display("Timeout: %s", what);
      error_count++;
      finish_run();
   endtask

   // Sender spends one credit per item
   task automatic drive_all();
      int waited;
      for (int i = 0; i < exp_instr.size(); i++) begin
         waited = 0;
         while (sent_count - in_credit_count >= IN_DEPTH) begin
            if (waited >= WAIT_LIMIT) begin
               fail_timeout("the DUT returned no input credit");
            end
            waited++;
            @(posedge clock);
            #DRIVE_DELAY;
         end
         instr_valid = 1'b1;
         instr       = exp_instr[i];
         sent_count++;
         @(posedge clock);
         #DRIVE_DELAY;
         instr_valid = 1'b0;
      end
   endtask

   function automatic string format_record(result_t rec);
      return $sformatf("op=%h val=%h flags=%b taken=%b illegal=%b",
                       rec.opcode, rec.value, rec.flags, rec.taken, rec.illegal);
   endfunction

   // Records are taken mid-cycle with one per cycle of result_valid
   task automatic collect_results();
      int      waited;
      logic    ok;
      result_t got;
      result_t exp;
      for (int i = 0; i < exp_result.size(); i++) begin
         waited = 0;
         @(negedge clock);
         while (result_valid !== 1'b1) begin
            if (waited >= WAIT_LIMIT) begin
               fail_timeout($sformatf("no result record arrived for %s", exp_name[i]));
            end
            waited++;
            @(negedge clock);
         end
         got = result;
         exp = exp_result[i];
         recv_count++;
         ok  = 1'b1;
         assert (got === exp) else begin
            ok = 1'b0;
            error_count++;
            $display("CHECK FAILED %s expected %s actual %s",
                     exp_name[i], format_record(exp), format_record(got));
         end
         if (ok) begin
            pass_count++;
            $display("ok   %-16s val=%h flags=%b taken=%b illegal=%b",
                     exp_name[i], got.value, got.flags, got.taken, got.illegal);
         end
      end
   endtask

   // Consumer hands credits back at a slow random pace
   task automatic return_credits();
      int          idle;
      logic [31:0] pick;
      idle = 0;
      while (returned_count < exp_result.size()) begin
         @(posedge clock);
         #DRIVE_DELAY;
         out_credit = 1'b0;
         if (recv_count > returned_count) begin
            idle = 0;
            pick = lcg_next();
            if (pick[31:30] == 2'b00) begin
               out_credit = 1'b1;
               returned_count++;
            end
         end else begin
            if (idle >= WAIT_LIMIT) begin
               fail_timeout("the consumer received no record to return a credit for");
            end
            idle++;
         end
      end
      @(posedge clock);
      #DRIVE_DELAY;
      out_credit = 1'b0;
   endtask

   initial begin
      reset       = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      out_credit  = 1'b0;
      load_directed_cases();
      build_random_cases();
      repeat (3) @(posedge clock);
      #DRIVE_DELAY;
      reset = 1'b0;
      fork
         drive_all();
         collect_results();
         return_credits();
      join
      // Every dequeued item hands its input credit back
      assert (in_credit_count == sent_count) else begin
         error_count++;
         $display("CHECK FAILED input_credits expected %0d actual %0d",
                  sent_count, in_credit_count);
      end
      finish_run();
   end

   `include "tb_cases.svh"

endmodule

`default_nettype wire

//--- design/gb_exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module gb_exec_core #(
   parameter int IN_DEPTH    = gb_exec_pkg::IN_DEPTH_DEFAULT,
   parameter int OUT_CREDITS = gb_exec_pkg::OUT_CREDITS_DEFAULT
) (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 instr_valid,
   input  gb_exec_pkg::instr_t  instr,
   input  logic                 out_credit,
   output logic                 in_credit,
   output logic                 result_valid,
   output gb_exec_pkg::result_t result
);
   import gb_exec_pkg::*;

   // Decode to execute
   logic    uop_valid;
   uop_t    uop;
   logic    exec_ready;

   // Execute to result queue
   logic    res_valid;
   result_t res;
   logic    queue_space;

   instr_decode #(
      .IN_DEPTH (IN_DEPTH)
   ) u_decode (
      .clock       (clock),
      .reset       (reset),
      .instr_valid (instr_valid),
      .instr       (instr),
      .exec_ready  (exec_ready),
      .in_credit   (in_credit),
      .uop_valid   (uop_valid),
      .uop         (uop)
   );

   alu_execute u_execute (
      .clock       (clock),
      .reset       (reset),
      .uop_valid   (uop_valid),
      .uop         (uop),
      .queue_space (queue_space),
      .exec_ready  (exec_ready),
      .res_valid   (res_valid),
      .result      (res)
   );

   result_queue #(
      .OUT_CREDITS (OUT_CREDITS)
   ) u_result (
      .clock        (clock),
      .reset        (reset),
      .res_valid    (res_valid),
      .result_in    (res),
      .out_credit   (out_credit),
      .queue_space  (queue_space),
      .result_valid (result_valid),
      .result       (result)
   );

endmodule

`default_nettype wire

//--- design/result_queue.sv
`timescale 1ns/100ps
`default_nettype none

module result_queue #(
   parameter int OUT_CREDITS = gb_exec_pkg::OUT_CREDITS_DEFAULT
) (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 res_valid,
   input  gb_exec_pkg::result_t result_in,
   input  logic                 out_credit,
   output logic                 queue_space,
   output logic                 result_valid,
   output gb_exec_pkg::result_t result
);
   import gb_exec_pkg::*;

   // One slot beyond the credits covers the record in flight
   localparam int DEPTH = OUT_CREDITS + 1;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam int CRD_W = $clog2(OUT_CREDITS + 1);

   result_t          mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CRD_W-1:0] credits;
   logic             send;

   // Head goes out whenever a credit is held
   assign send         = (count != '0) && (credits != '0);
   assign result_valid = send;
   assign result       = mem[rd_ptr];

   // Count the record already in the execute register
   assign queue_space = (int'(count) + int'(res_valid)) < DEPTH;

   always_ff @(posedge clock) begin
      if (res_valid) begin
         mem[wr_ptr] <= result_in;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= CRD_W'(OUT_CREDITS);
      end else begin
         if (res_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (send) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count   <= count + CNT_W'(res_valid) - CNT_W'(send);
         // Spend on send, refill on consumer pulse
         credits <= credits + CRD_W'(out_credit) - CRD_W'(send);
      end
   end

   // Consumer never returns more than it was given
   a_credit_bound : assert property (
      @(posedge clock) disable iff (reset)
      credits <= CRD_W'(OUT_CREDITS)
   );

endmodule

`default_nettype wire

//--- design/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 uop_valid,
   input  gb_exec_pkg::uop_t    uop,
   input  logic                 queue_space,
   output logic                 exec_ready,
   output logic                 res_valid,
   output gb_exec_pkg::result_t result
);
   import gb_exec_pkg::*;

   // Register file by Game Boy code, entry 6 stays zero
   logic [7:0] regs [8];
   logic [3:0] flags;

   logic       take;
   logic [7:0] operand_a;
   logic [7:0] operand_b;
   logic       cin;
   logic [8:0] sum9;
   logic [4:0] half_sum;
   logic [8:0] diff9;
   logic [4:0] half_diff;
   logic [7:0] alu_val;
   logic [3:0] alu_flags;
   logic [7:0] unary_in;
   logic [7:0] unary_val;
   logic       unary_h;
   logic [7:0] nxt_value;
   logic [3:0] nxt_flags;
   logic       nxt_taken;
   logic       wr_en;
   reg_code_t  wr_reg;

   assign exec_ready = queue_space;
   assign take       = uop_valid && queue_space;

   // ALU operands
   assign operand_a = regs[REG_A];
   assign operand_b = (uop.kind == ALU_IMM) ? uop.imm : regs[uop.src];
   assign cin       = (uop.op == ALU_ADC || uop.op == ALU_SBC) ? flags[FLAG_C] : 1'b0;

   // Adder and subtractor with nibble carry
   assign sum9      = {1'b0, operand_a} + {1'b0, operand_b} + {8'd0, cin};
   assign half_sum  = {1'b0, operand_a[3:0]} + {1'b0, operand_b[3:0]} + {4'd0, cin};
   assign diff9     = {1'b0, operand_a} - {1'b0, operand_b} - {8'd0, cin};
   assign half_diff = {1'b0, operand_a[3:0]} - {1'b0, operand_b[3:0]} - {4'd0, cin};

   always_comb begin
      alu_val   = 8'h00;
      alu_flags = 4'b0000;
      case (uop.op)
         ALU_ADD, ALU_ADC: begin
            alu_val           = sum9[7:0];
            alu_flags[FLAG_H] = half_sum[4];
            alu_flags[FLAG_C] = sum9[8];
         end
         ALU_SUB, ALU_SBC, ALU_CP: begin
            // Top bit of the wide difference is the borrow
            alu_val           = diff9[7:0];
            alu_flags[FLAG_N] = 1'b1;
            alu_flags[FLAG_H] = half_diff[4];
            alu_flags[FLAG_C] = diff9[8];
         end
         ALU_AND: begin
            alu_val           = operand_a & operand_b;
            alu_flags[FLAG_H] = 1'b1;
         end
         ALU_XOR: begin
            alu_val = operand_a ^ operand_b;
         end
         ALU_OR: begin
            alu_val = operand_a | operand_b;
         end
      endcase
      alu_flags[FLAG_Z] = (alu_val == 8'h00);
   end

   // INC and DEC on the destination register
   assign unary_in  = regs[uop.dst];
   assign unary_val = (uop.kind == DEC) ? unary_in - 8'd1 : unary_in + 8'd1;
   // Half carry out of bit 3 or borrow into bit 4
   assign unary_h   = (uop.kind == DEC) ? (unary_in[3:0] == 4'h0) : (unary_in[3:0] == 4'hf);

   // Write-back selection per kind
   always_comb begin
      nxt_value = 8'h00;
      nxt_flags = flags;
      nxt_taken = 1'b0;
      wr_en     = 1'b0;
      wr_reg    = uop.dst;
      case (uop.kind)
         MOVE: begin
            nxt_value = regs[uop.src];
            wr_en     = 1'b1;
         end
         LOAD_IMM: begin
            nxt_value = uop.imm;
            wr_en     = 1'b1;
         end
         ALU_REG, ALU_IMM: begin
            // CP reports A and leaves it alone
            wr_reg    = REG_A;
            wr_en     = (uop.op != ALU_CP);
            nxt_value = (uop.op == ALU_CP) ? operand_a : alu_val;
            nxt_flags = alu_flags;
         end
         INC, DEC: begin
            nxt_value         = unary_val;
            wr_en             = 1'b1;
            nxt_flags[FLAG_Z] = (unary_val == 8'h00);
            nxt_flags[FLAG_N] = (uop.kind == DEC);
            nxt_flags[FLAG_H] = unary_h;
         end
         JUMP_COND: begin
            case (uop.cond)
               2'b00:   nxt_taken = !flags[FLAG_Z];
               2'b01:   nxt_taken = flags[FLAG_Z];
               2'b10:   nxt_taken = !flags[FLAG_C];
               default: nxt_taken = flags[FLAG_C];
            endcase
         end
         default: begin
            // ILLEGAL touches no state
         end
      endcase
   end

   // Architectural state
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= 8'h00;
         end
         flags     <= 4'b0000;
         res_valid <= 1'b0;
      end else begin
         res_valid <= take;
         if (take) begin
            if (wr_en) begin
               regs[wr_reg] <= nxt_value;
            end
            flags <= nxt_flags;
         end
      end
   end

   // Result record payload
   always_ff @(posedge clock) begin
      if (take) begin
         result.opcode  <= uop.opcode;
         result.value   <= nxt_value;
         result.flags   <= nxt_flags;
         result.taken   <= nxt_taken;
         result.illegal <= (uop.kind == ILLEGAL);
      end
   end

   // A stalled uop stays put until the result queue has room
   a_hold_stalled : assert property (
      @(posedge clock) disable iff (reset)
      uop_valid && !queue_space |=> uop_valid && $stable(uop)
   );

endmodule

`default_nettype wire

//--- design/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode #(
   parameter int IN_DEPTH = gb_exec_pkg::IN_DEPTH_DEFAULT
) (
   input  logic                clock,
   input  logic                reset,
   input  logic                instr_valid,
   input  gb_exec_pkg::instr_t instr,
   input  logic                exec_ready,
   output logic                in_credit,
   output logic                uop_valid,
   output gb_exec_pkg::uop_t   uop
);
   import gb_exec_pkg::*;

   localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
   localparam int CNT_W = $clog2(IN_DEPTH + 1);

   // Circular input queue storage
   instr_t           queue_mem [IN_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   instr_t  head;
   opcode_u op_u;
   uop_t    dec;
   logic    load_uop;
   logic    deq;

   assign head = queue_mem[rd_ptr];
   assign op_u = head.opcode;

   // Uop slot is free or drains this cycle
   assign load_uop = !uop_valid || exec_ready;
   assign deq      = (count != '0) && load_uop;

   // Storage written as the sender presents an item
   always_ff @(posedge clock) begin
      if (instr_valid) begin
         queue_mem[wr_ptr] <= instr;
      end
   end

   // Queue pointers and occupancy
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (instr_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (deq) begin
            rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(instr_valid) - CNT_W'(deq);
      end
   end

   // Opcode classification
   always_comb begin
      dec.kind   = ILLEGAL;
      dec.op     = op_u.alu_view.op;
      dec.dst    = op_u.move_view.dst;
      dec.src    = op_u.move_view.src;
      dec.cond   = head.opcode[4:3];
      dec.imm    = head.imm;
      dec.opcode = head.opcode;
      case (op_u.move_view.group)
         2'b01: begin
            // LD r,r' but HALT has 6 in both fields
            if (op_u.move_view.dst != REG_MEM && op_u.move_view.src != REG_MEM) begin
               dec.kind = MOVE;
            end
         end
         2'b10: begin
            if (op_u.alu_view.src != REG_MEM) begin
               dec.kind = ALU_REG;
            end
         end
         2'b11: begin
            // Low field 6 selects the immediate operand
            if (op_u.alu_view.src == REG_MEM) begin
               dec.kind = ALU_IMM;
            end
         end
         default: begin
            if (head.opcode[5] && head.opcode[2:0] == 3'b000) begin
               // JR NZ/Z/NC/C
               dec.kind = JUMP_COND;
            end else if (op_u.move_view.dst != REG_MEM) begin
               case (op_u.move_view.src)
                  REG_MEM: dec.kind = LOAD_IMM;
                  REG_H:   dec.kind = INC;
                  REG_L:   dec.kind = DEC;
                  default: dec.kind = ILLEGAL;
               endcase
            end
         end
      endcase
   end

   // Uop valid and credit return
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         uop_valid <= 1'b0;
         in_credit <= 1'b0;
      end else begin
         if (load_uop) begin
            uop_valid <= deq;
         end
         in_credit <= deq;
      end
   end

   // Uop payload
   always_ff @(posedge clock) begin
      if (deq) begin
         uop <= dec;
      end
   end

   // Sender overran its credits
   a_no_overflow : assert property (
      @(posedge clock) disable iff (reset)
      instr_valid |-> count != CNT_W'(IN_DEPTH)
   );

endmodule

`default_nettype wire

//--- design/gb_exec_pkg.sv
`default_nettype none

package gb_exec_pkg;

   // Register numbers in Game Boy order
   // Code 6 is the (HL) memory form, not supported here
   typedef enum logic [2:0] {
      REG_B   = 3'd0,
      REG_C   = 3'd1,
      REG_D   = 3'd2,
      REG_E   = 3'd3,
      REG_H   = 3'd4,
      REG_L   = 3'd5,
      REG_MEM = 3'd6,
      REG_A   = 3'd7
   } reg_code_t;

   // Same order as opcode bits 5:3 of the ALU groups
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_ADC = 3'd1,
      ALU_SUB = 3'd2,
      ALU_SBC = 3'd3,
      ALU_AND = 3'd4,
      ALU_XOR = 3'd5,
      ALU_OR  = 3'd6,
      ALU_CP  = 3'd7
   } alu_op_t;

   // Bit positions inside the flag nibble
   localparam int FLAG_Z = 3;
   localparam int FLAG_N = 2;
   localparam int FLAG_H = 1;
   localparam int FLAG_C = 0;

   // Opcode seen as group / operation / source
   typedef struct packed {
      logic [1:0] group;
      alu_op_t    op;
      reg_code_t  src;
   } alu_view_t;

   // Opcode seen as group / destination / source
   typedef struct packed {
      logic [1:0] group;
      reg_code_t  dst;
      reg_code_t  src;
   } move_view_t;

   // Middle field is either an ALU op or a destination register
   typedef union packed {
      alu_view_t  alu_view;
      move_view_t move_view;
   } opcode_u;

   typedef enum logic [2:0] {
      MOVE      = 3'd0,
      LOAD_IMM  = 3'd1,
      ALU_REG   = 3'd2,
      ALU_IMM   = 3'd3,
      INC       = 3'd4,
      DEC       = 3'd5,
      JUMP_COND = 3'd6,
      ILLEGAL   = 3'd7
   } uop_kind_t;

   // One item of the input stream
   typedef struct packed {
      logic [7:0] opcode;
      logic [7:0] imm;
   } instr_t;

   // Decoded operation, decode to execute
   typedef struct packed {
      uop_kind_t  kind;
      alu_op_t    op;
      reg_code_t  dst;
      reg_code_t  src;
      logic [1:0] cond;
      logic [7:0] imm;
      logic [7:0] opcode;
   } uop_t;

   // One record of the output stream
   typedef struct packed {
      logic [7:0] opcode;
      logic [7:0] value;
      logic [3:0] flags;
      logic       taken;
      logic       illegal;
   } result_t;

   localparam int IN_DEPTH_DEFAULT    = 4;
   localparam int OUT_CREDITS_DEFAULT = 2;

endpackage

`default_nettype wire
